// File: rtl/io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// I/O port map, byte addresses of 16-bit words

// LED output register
`define IO_LEDS_ADDR 16'hfffe

// Interval timer, two consecutive words
`define IO_TIMER_RELOAD_ADDR 16'h0040
`define IO_TIMER_CTRL_ADDR 16'h0042

// Number of LED outputs, at most 16
`define IO_NUM_LEDS 8

`endif

// File: rtl/io_pkg.sv
package io_pkg;

    // Decoded destination of an I/O access
    typedef enum logic [1:0] {
        TARGET_NONE  = 2'd0, // Unmapped, answered by the router
        TARGET_LEDS  = 2'd1,
        TARGET_TIMER = 2'd2
    } io_target_e;

    // Interval timer state, follows the enable bit
    typedef enum logic {
        TIMER_IDLE     = 1'b0,
        TIMER_COUNTING = 1'b1
    } timer_state_e;

endpackage

// File: rtl/io_slave_if.sv
`timescale 1ns/1ps

interface io_slave_if;

    logic        cs;      // Single cycle select for this peripheral
    logic        wr_en;
    logic [1:0]  bytesel;
    logic [15:0] wdata;
    logic        reg_sel; // Word address bit 1

    // Response, one cycle after cs
    logic [15:0] rdata;   // Zero unless ack is high
    logic        ack;

    modport router (
        output cs,
        output wr_en,
        output bytesel,
        output wdata,
        output reg_sel,
        input  rdata,
        input  ack
    );

    modport peripheral (
        input  cs,
        input  wr_en,
        input  bytesel,
        input  wdata,
        input  reg_sel,
        output rdata,
        output ack
    );

endinterface

// File: rtl/io_bus_router.sv
`timescale 1ns/1ps
`include "io_params.svh"

module io_bus_router (
    input  logic        sys_clk,
    input  logic        reset,
    input  logic        io_access,
    input  logic [15:1] io_addr,
    input  logic        io_wr_en,
    input  logic [1:0]  io_bytesel,
    input  logic [15:0] io_wdata,
    output logic [15:0] io_rdata,
    output logic        io_ack,
    io_slave_if.router  leds_port,
    io_slave_if.router  timer_port
);

    logic [15:0]        byte_addr;
    io_pkg::io_target_e target;
    logic               default_ack;

    assign byte_addr = {io_addr, 1'b0};

    always_comb begin
        case (byte_addr)
            `IO_LEDS_ADDR: begin
                target = io_pkg::TARGET_LEDS;
            end
            `IO_TIMER_RELOAD_ADDR,
            `IO_TIMER_CTRL_ADDR: begin
                target = io_pkg::TARGET_TIMER;
            end
            default: begin
                target = io_pkg::TARGET_NONE;
            end
        endcase
    end

    // LED register port
    assign leds_port.cs      = io_access && (target == io_pkg::TARGET_LEDS);
    assign leds_port.wr_en   = io_wr_en;
    assign leds_port.bytesel = io_bytesel;
    assign leds_port.wdata   = io_wdata;
    assign leds_port.reg_sel = io_addr[1];

    // Timer port, reg_sel picks reload or control
    assign timer_port.cs      = io_access && (target == io_pkg::TARGET_TIMER);
    assign timer_port.wr_en   = io_wr_en;
    assign timer_port.bytesel = io_bytesel;
    assign timer_port.wdata   = io_wdata;
    assign timer_port.reg_sel = io_addr[1];

    // Unmapped accesses still get their ack
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= io_access && (target == io_pkg::TARGET_NONE);
        end
    end

    // Idle responders drive zero, so a plain OR merges them
    assign io_ack   = leds_port.ack | timer_port.ack | default_ack;
    assign io_rdata = leds_port.rdata | timer_port.rdata; // Default data is zero

    ack_onehot: assert property (
        @(posedge sys_clk) disable iff (reset)
        $onehot0({leds_port.ack, timer_port.ack, default_ack})
    ) else $error("more than one responder acked in the same cycle");

    access_acked: assert property (
        @(posedge sys_clk) disable iff (reset)
        io_access |=> io_ack
    ) else $error("access not acknowledged on the next cycle");

endmodule

// File: rtl/leds_register.sv
`timescale 1ns/1ps
`include "io_params.svh"

module leds_register (
    input  logic                    sys_clk,
    input  logic                    reset,
    io_slave_if.peripheral          bus,
    output logic [`IO_NUM_LEDS-1:0] leds
);

    logic [15:0] leds_reg;
    logic        wr_access;

    assign wr_access = bus.cs && bus.wr_en;

    // Byte lane writes
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            leds_reg <= '0;
        end else if (wr_access) begin
            if (bus.bytesel[0])
                leds_reg[7:0] <= bus.wdata[7:0];
            if (bus.bytesel[1])
                leds_reg[15:8] <= bus.wdata[15:8];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            bus.ack   <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ack   <= bus.cs;
            bus.rdata <= (bus.cs && !bus.wr_en) ? leds_reg : 16'h0000; // Writes return 0
        end
    end

    assign leds = leds_reg[`IO_NUM_LEDS-1:0];

endmodule

// File: rtl/pit_timer.sv
`timescale 1ns/1ps

module pit_timer (
    input  logic           sys_clk,
    input  logic           reset,
    io_slave_if.peripheral bus,
    output logic           timer_intr
);

    io_pkg::timer_state_e state;
    logic [15:0]          reload_val;
    logic [15:0]          reload_next;
    logic [15:0]          count;
    logic [15:0]          read_val;
    logic                 pending;
    logic                 enabled;
    logic                 reload_wr;
    logic                 ctrl_wr;
    logic                 zero_event;

    assign reload_wr = bus.cs && bus.wr_en && !bus.reg_sel;
    assign ctrl_wr   = bus.cs && bus.wr_en && bus.reg_sel && bus.bytesel[0]; // Low byte only

    assign enabled    = (state == io_pkg::TIMER_COUNTING);
    assign zero_event = enabled && (count == 16'h0000);
    assign timer_intr = zero_event;

    // Reload value after a byte lane write
    assign reload_next = {bus.bytesel[1] ? bus.wdata[15:8] : reload_val[15:8],
                          bus.bytesel[0] ? bus.wdata[7:0] : reload_val[7:0]};

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            reload_val <= '0;
        end else if (reload_wr) begin
            reload_val <= reload_next;
        end
    end

    // Enable bit is held as the FSM state
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state <= io_pkg::TIMER_IDLE;
        end else if (ctrl_wr) begin
            case (state)
                io_pkg::TIMER_IDLE: begin
                    if (bus.wdata[0])
                        state <= io_pkg::TIMER_COUNTING;
                end
                io_pkg::TIMER_COUNTING: begin
                    if (!bus.wdata[0])
                        state <= io_pkg::TIMER_IDLE;
                end
                default: begin
                    state <= io_pkg::TIMER_IDLE;
                end
            endcase
        end
    end

    // Any register write restarts the count
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            count <= '0;
        end else if (reload_wr) begin
            count <= reload_next;
        end else if (ctrl_wr || zero_event) begin
            count <= reload_val;
        end else if (enabled) begin
            count <= count - 16'd1;
        end
    end

    // A new expiry beats the clearing write
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (zero_event) begin
            pending <= 1'b1;
        end else if (ctrl_wr && bus.wdata[1]) begin
            pending <= 1'b0;
        end
    end

    assign read_val = bus.reg_sel ? {14'b0, pending, enabled} : reload_val;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            bus.ack   <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ack   <= bus.cs;
            bus.rdata <= (bus.cs && !bus.wr_en) ? read_val : 16'h0000;
        end
    end

    intr_only_counting: assert property (
        @(posedge sys_clk) disable iff (reset)
        timer_intr |-> (state == io_pkg::TIMER_COUNTING)
    ) else $error("timer interrupt raised while idle");

endmodule

// File: rtl/io_subsystem.sv
`timescale 1ns/1ps
`include "io_params.svh"

module io_subsystem (
    input  logic                    sys_clk,
    input  logic                    reset,
    input  logic                    io_access,
    input  logic [15:1]             io_addr,
    input  logic                    io_wr_en,
    input  logic [1:0]              io_bytesel,
    input  logic [15:0]             io_wdata,
    output logic [15:0]             io_rdata,
    output logic                    io_ack,
    output logic [`IO_NUM_LEDS-1:0] leds,
    output logic                    timer_intr
);

    io_slave_if leds_bus ();
    io_slave_if timer_bus ();

    io_bus_router i_io_bus_router (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .io_access  (io_access),
        .io_addr    (io_addr),
        .io_wr_en   (io_wr_en),
        .io_bytesel (io_bytesel),
        .io_wdata   (io_wdata),
        .io_rdata   (io_rdata),
        .io_ack     (io_ack),
        .leds_port  (leds_bus.router),
        .timer_port (timer_bus.router)
    );

    leds_register i_leds_register (
        .sys_clk (sys_clk),
        .reset   (reset),
        .bus     (leds_bus.peripheral),
        .leds    (leds)
    );

    // Interrupt goes straight out, no interrupt controller here
    pit_timer i_pit_timer (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .bus        (timer_bus.peripheral),
        .timer_intr (timer_intr)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic sys_clk,
    output logic reset
);

    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end

    // Released on a rising edge, after RESET_CYCLES edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        reset <= 1'b0;
    end

endmodule

// File: sim/tb_io_subsystem.sv
`timescale 1ns/1ps
`include "io_params.svh"

module tb_io_subsystem;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_RANDOM  = 400;
    localparam int NUM_DIRECT  = 30;  // Upper bound on directed accesses
    localparam int DIRECT_IDLE = 60;
    localparam int MAX_GAP     = 4;   // Access cycle plus up to 3 idle cycles
    localparam int MARGIN      = 100;
    localparam int TIMEOUT_NS  =
        ((NUM_RANDOM + NUM_DIRECT) * MAX_GAP + DIRECT_IDLE + MARGIN) * CLK_PERIOD;

    localparam logic [15:0] LEDS_BYTE   = `IO_LEDS_ADDR;
    localparam logic [15:0] RELOAD_BYTE = `IO_TIMER_RELOAD_ADDR;
    localparam logic [15:0] CTRL_BYTE   = `IO_TIMER_CTRL_ADDR;
    localparam logic [14:0] LEDS_ADDR   = LEDS_BYTE[15:1];
    localparam logic [14:0] RELOAD_ADDR = RELOAD_BYTE[15:1];
    localparam logic [14:0] CTRL_ADDR   = CTRL_BYTE[15:1];

    logic                    sys_clk;
    logic                    reset;
    logic                    io_access;
    logic [15:1]             io_addr;
    logic                    io_wr_en;
    logic [1:0]              io_bytesel;
    logic [15:0]             io_wdata;
    logic [15:0]             io_rdata;
    logic                    io_ack;
    logic [`IO_NUM_LEDS-1:0] leds;
    logic                    timer_intr;

    // Reference model state
    logic [15:0] m_leds;
    logic [15:0] m_reload;
    logic [15:0] m_count;
    logic        m_enable;
    logic        m_pending;
    logic        exp_ack;
    logic [15:0] exp_rdata;

    logic [15:0] lfsr_state;
    int          value_errors;
    int          protocol_errors;
    int          pulse_count;
    int          txn_count;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) i_tb_clock_gen (
        .sys_clk (sys_clk),
        .reset   (reset)
    );

    io_subsystem i_io_subsystem (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .io_access  (io_access),
        .io_addr    (io_addr),
        .io_wr_en   (io_wr_en),
        .io_bytesel (io_bytesel),
        .io_wdata   (io_wdata),
        .io_rdata   (io_rdata),
        .io_ack     (io_ack),
        .leds       (leds),
        .timer_intr (timer_intr)
    );

    // Galois LFSR, one step per bit
    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] value;
        logic        out_bit;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit)
                lfsr_state = lfsr_state ^ 16'hb400;
            value = {value[14:0], out_bit};
        end
        return value;
    endfunction

    function automatic logic is_leds(input logic [15:1] addr);
        return {addr, 1'b0} == LEDS_BYTE;
    endfunction

    function automatic logic is_reload(input logic [15:1] addr);
        return {addr, 1'b0} == RELOAD_BYTE;
    endfunction

    function automatic logic is_ctrl(input logic [15:1] addr);
        return {addr, 1'b0} == CTRL_BYTE;
    endfunction

    function automatic logic [15:1] pick_unmapped();
        logic [15:0] value;
        logic [15:1] addr;
        addr = LEDS_ADDR;
        while (is_leds(addr) || is_reload(addr) || is_ctrl(addr)) begin
            value = rand_bits(15);
            addr  = value[14:0];
        end
        return addr;
    endfunction

    task automatic report_value(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic reset_model();
        m_leds    = '0;
        m_reload  = '0;
        m_count   = '0;
        m_enable  = 1'b0;
        m_pending = 1'b0;
        exp_ack   = 1'b0;
        exp_rdata = '0;
    endtask

    task automatic check_outputs();
        logic exp_intr;
        exp_intr = m_enable && (m_count == 16'h0000); // Pulse while the count sits at zero
        if (exp_ack && !io_ack) begin
            $display("Missing ack at %0t ns, the access one cycle earlier got no answer",
                     $time);
            protocol_errors++;
        end
        if (!exp_ack && io_ack) begin
            $display("Extra ack at %0t ns without an access one cycle earlier", $time);
            protocol_errors++;
        end
        if (io_rdata !== exp_rdata)
            report_value("io_rdata", exp_rdata, io_rdata);
        if (leds !== m_leds[`IO_NUM_LEDS-1:0])
            report_value("leds", 16'(m_leds[`IO_NUM_LEDS-1:0]), 16'(leds));
        if (timer_intr !== exp_intr)
            report_value("timer_intr", 16'(exp_intr), 16'(timer_intr));
        if (timer_intr === 1'b1)
            pulse_count++;
    endtask

    // Advance the model by the edge that follows
    task automatic step_model();
        logic        zero_hit;
        logic        reload_wr;
        logic        ctrl_wr;
        logic [15:0] new_reload;
        logic [15:0] read_val;
        zero_hit   = m_enable && (m_count == 16'h0000);
        reload_wr  = io_access && io_wr_en && is_reload(io_addr);
        ctrl_wr    = io_access && io_wr_en && is_ctrl(io_addr) && io_bytesel[0];
        new_reload = m_reload;
        if (io_bytesel[0])
            new_reload[7:0] = io_wdata[7:0];
        if (io_bytesel[1])
            new_reload[15:8] = io_wdata[15:8];

        read_val = 16'h0000; // Writes and unmapped reads answer zero
        if (io_access && !io_wr_en) begin
            if (is_leds(io_addr))
                read_val = m_leds;
            else if (is_reload(io_addr))
                read_val = m_reload;
            else if (is_ctrl(io_addr))
                read_val = {14'b0, m_pending, m_enable};
        end
        exp_ack   = io_access;
        exp_rdata = read_val;

        if (io_access && io_wr_en && is_leds(io_addr)) begin
            if (io_bytesel[0])
                m_leds[7:0] = io_wdata[7:0];
            if (io_bytesel[1])
                m_leds[15:8] = io_wdata[15:8];
        end

        if (reload_wr)
            m_count = new_reload;
        else if (ctrl_wr || zero_hit)
            m_count = m_reload;
        else if (m_enable)
            m_count = m_count - 16'd1;

        if (zero_hit)
            m_pending = 1'b1; // Set beats a clearing write
        else if (ctrl_wr && io_wdata[1])
            m_pending = 1'b0;
        if (reload_wr)
            m_reload = new_reload;
        if (ctrl_wr)
            m_enable = io_wdata[0];
    endtask

    // Mid-cycle, inputs and outputs are both settled
    always @(negedge sys_clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check_outputs();
            step_model();
        end
    end

    task automatic drive_access(input logic [15:1] addr, input logic wr,
                                input logic [1:0] sel, input logic [15:0] data);
        @(posedge sys_clk);
        io_access  <= 1'b1;
        io_addr    <= addr;
        io_wr_en   <= wr;
        io_bytesel <= sel;
        io_wdata   <= data;
        txn_count++;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge sys_clk);
            io_access <= 1'b0;
            io_wr_en  <= 1'b0;
        end
    endtask

    task automatic write_reg(input logic [15:1] addr, input logic [1:0] sel,
                             input logic [15:0] data);
        drive_access(addr, 1'b1, sel, data);
    endtask

    task automatic read_reg(input logic [15:1] addr);
        drive_access(addr, 1'b0, 2'b11, 16'h0000);
    endtask

    task automatic run_random(input int count);
        logic [15:0] choice;
        logic [15:0] wr_bit;
        logic [15:0] sel;
        logic [15:0] gap;
        logic [15:0] data;
        logic [15:1] addr;
        int          n;
        for (n = 0; n < count; n++) begin
            choice = rand_bits(2);
            wr_bit = rand_bits(1);
            sel    = rand_bits(2);
            gap    = rand_bits(2); // Zero means back-to-back
            case (choice[1:0])
                2'd0: begin
                    addr = LEDS_ADDR;
                    data = rand_bits(16);
                end
                2'd1: begin
                    addr = RELOAD_ADDR;
                    data = rand_bits(4); // Short periods so pulses happen
                end
                2'd2: begin
                    addr = CTRL_ADDR;
                    data = rand_bits(2);
                end
                default: begin
                    addr = pick_unmapped();
                    data = rand_bits(16);
                end
            endcase
            drive_access(addr, wr_bit[0], sel[1:0], data);
            drive_idle(int'(gap));
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout at %0t ns, the run did not finish in time", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        lfsr_state      = 16'd76;
        value_errors    = 0;
        protocol_errors = 0;
        pulse_count     = 0;
        txn_count       = 0;
        io_access       = 1'b0;
        io_addr         = '0;
        io_wr_en        = 1'b0;
        io_bytesel      = 2'b00;
        io_wdata        = '0;

        wait (!reset);

        // Reset values, back-to-back reads
        read_reg(LEDS_ADDR);
        read_reg(RELOAD_ADDR);
        read_reg(CTRL_ADDR);
        read_reg(pick_unmapped());
        drive_idle(2);

        // Byte lanes, then a write that must go nowhere
        write_reg(LEDS_ADDR, 2'b01, 16'ha55a);
        write_reg(LEDS_ADDR, 2'b10, 16'h3cc3);
        read_reg(LEDS_ADDR);
        write_reg(pick_unmapped(), 2'b11, 16'hffff);
        read_reg(LEDS_ADDR);
        drive_idle(1);

        // Period of 6 cycles
        write_reg(RELOAD_ADDR, 2'b11, 16'd5);
        write_reg(CTRL_ADDR, 2'b01, 16'h0001);
        drive_idle(20);
        read_reg(CTRL_ADDR);
        read_reg(CTRL_ADDR);
        write_reg(CTRL_ADDR, 2'b01, 16'h0003); // Clear pending, stay enabled
        read_reg(CTRL_ADDR);
        write_reg(CTRL_ADDR, 2'b01, 16'h0002);
        drive_idle(15);
        read_reg(CTRL_ADDR);

        // Reload of zero fires every cycle
        write_reg(RELOAD_ADDR, 2'b11, 16'h0000);
        write_reg(CTRL_ADDR, 2'b01, 16'h0001);
        drive_idle(6);
        write_reg(CTRL_ADDR, 2'b01, 16'h0002);
        drive_idle(2);

        run_random(NUM_RANDOM);
        drive_idle(3);

        if (pulse_count == 0) begin
            $display("No timer interrupt was seen during the run");
            protocol_errors++;
        end

        $display("Accesses: %0d, interrupts: %0d, value errors: %0d, protocol errors: %0d",
                 txn_count, pulse_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/io_pkg.sv
rtl/io_slave_if.sv
rtl/io_bus_router.sv
rtl/leds_register.sv
rtl/pit_timer.sv
rtl/io_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_io_subsystem.sv

// File: Makefile
# Verilator flow for the I/O subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_io_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
